/* rtl/cp0_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_regs #(
    parameter int TIMER_DIV = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cwrite_en,
    input  mips_pkg::creg_addr_t cwrite_addr,
    input  mips_pkg::word_t      cwrite_data,
    input  mips_pkg::creg_addr_t read_addr,
    input  logic                 is_eret,
    input  mips_pkg::word_t      pc,
    input  logic                 in_delay_slot,
    input  logic [5:0]           ext_int,
    input  logic                 exc_valid,
    input  mips_pkg::exccode_t   exc_code,
    input  mips_pkg::word_t      exc_badvaddr,
    output mips_pkg::word_t      read_data,
    output mips_pkg::status_t    status,
    output mips_pkg::cause_t     cause,
    output mips_pkg::word_t      epc
);
    import mips_pkg::*;

    localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

    cp0_regs_t cp0, cp0_new;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic             wr_ok;
    logic             count_wr;
    logic             compare_wr;

    assign wr_ok      = cwrite_en & ~exc_valid;   // exception wins over mtc0
    assign count_wr   = wr_ok && (cwrite_addr == REG_COUNT);
    assign compare_wr = wr_ok && (cwrite_addr == REG_COMPARE);
    assign tick       = (div_cnt == DIV_W'(TIMER_DIV - 1));

    // ----------------------------------------
    // state and timer divider
    // ----------------------------------------
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cp0 <= CP0_RESET;
        end else begin
            cp0 <= cp0_new;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (count_wr || tick) begin
            div_cnt <= '0;   // a Count write restarts the period
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // mfc0, Compare reads back as zero
    always_comb begin
        case (read_addr)
            REG_BADVADDR: read_data = cp0.badvaddr;
            REG_COUNT:    read_data = cp0.count;
            REG_STATUS:   read_data = cp0.status;
            REG_CAUSE:    read_data = cp0.cause;
            REG_EPC:      read_data = cp0.epc;
            REG_CONFIG:   read_data = cp0.config_;
            default:      read_data = '0;
        endcase
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        cp0_new = cp0;

        // mtc0
        if (wr_ok) begin
            case (cwrite_addr)
                REG_COUNT:   cp0_new.count = cwrite_data;
                REG_COMPARE: begin
                    cp0_new.compare  = cwrite_data;
                    cp0_new.cause.ti = 1'b0;
                end
                REG_STATUS: begin
                    cp0_new.status.im  = cwrite_data[15:8];
                    cp0_new.status.exl = cwrite_data[1];
                    cp0_new.status.ie  = cwrite_data[0];
                end
                REG_CAUSE:   cp0_new.cause.ip[1:0] = cwrite_data[9:8];
                REG_EPC:     cp0_new.epc = cwrite_data;
                default: ;
            endcase
        end

        // timer
        if (!count_wr && tick) begin
            cp0_new.count = cp0.count + 32'd1;
        end
        if (!compare_wr && (cp0.count == cp0.compare)) begin
            cp0_new.cause.ti = 1'b1;
        end

        // hardware pending bits, timer shares line 5
        cp0_new.cause.ip[7:2] = {ext_int[5] | cp0_new.cause.ti, ext_int[4:0]};

        // exception entry
        if (exc_valid) begin
            if (!cp0.status.exl) begin
                cp0_new.cause.bd = in_delay_slot;
                cp0_new.epc      = in_delay_slot ? pc - 32'd4 : pc;
            end
            cp0_new.cause.exccode = exc_code;
            cp0_new.status.exl    = 1'b1;
            if (exc_code == CODE_ADEL || exc_code == CODE_ADES) begin
                cp0_new.badvaddr = exc_badvaddr;
            end
        end

        if (is_eret) begin
            if (cp0.status.erl) begin
                cp0_new.status.erl = 1'b0;
            end else begin
                cp0_new.status.exl = 1'b0;
            end
        end
    end

    assign status = cp0.status;
    assign cause  = cp0.cause;
    assign epc    = cp0.epc;

endmodule

`default_nettype wire

/* rtl/cp0_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_top #(
    parameter int TIMER_DIV = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cwrite_en,
    input  mips_pkg::creg_addr_t cwrite_addr,
    input  mips_pkg::word_t      cwrite_data,
    input  mips_pkg::creg_addr_t read_addr,
    input  logic                 is_eret,
    input  mips_pkg::word_t      pc,
    input  logic                 in_delay_slot,
    input  logic                 fetch_adel,
    input  logic                 inst_ri,
    input  logic                 inst_syscall,
    input  logic                 inst_break,
    input  logic                 overflow,
    input  logic                 mem_adel,
    input  logic                 mem_ades,
    input  mips_pkg::word_t      mem_addr,
    input  logic [5:0]           ext_int,
    input  logic                 branch_taken,
    input  mips_pkg::word_t      branch_target,
    output mips_pkg::word_t      read_data,
    output mips_pkg::word_t      next_pc,
    output logic                 flush
);
    import mips_pkg::*;

    logic     exc_valid;
    exccode_t exc_code;
    word_t    exc_badvaddr;
    status_t  status;
    cause_t   cause;
    word_t    epc;

    // ----------------------------------------
    // exception arbitration
    // ----------------------------------------
    exception_unit u_exception_unit (
        .status       (status),
        .cause        (cause),
        .ext_int      (ext_int),
        .pc           (pc),
        .fetch_adel   (fetch_adel),
        .inst_ri      (inst_ri),
        .inst_syscall (inst_syscall),
        .inst_break   (inst_break),
        .overflow     (overflow),
        .mem_adel     (mem_adel),
        .mem_ades     (mem_ades),
        .mem_addr     (mem_addr),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_badvaddr (exc_badvaddr)
    );

    cp0_regs #(
        .TIMER_DIV (TIMER_DIV)
    ) u_cp0_regs (
        .clk           (clk),
        .reset         (reset),
        .cwrite_en     (cwrite_en),
        .cwrite_addr   (cwrite_addr),
        .cwrite_data   (cwrite_data),
        .read_addr     (read_addr),
        .is_eret       (is_eret),
        .pc            (pc),
        .in_delay_slot (in_delay_slot),
        .ext_int       (ext_int),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .exc_badvaddr  (exc_badvaddr),
        .read_data     (read_data),
        .status        (status),
        .cause         (cause),
        .epc           (epc)
    );

    // ----------------------------------------
    // fetch redirect
    // ----------------------------------------
    pc_select u_pc_select (
        .pc            (pc),
        .exc_valid     (exc_valid),
        .is_eret       (is_eret),
        .epc           (epc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .next_pc       (next_pc),
        .flush         (flush)
    );

endmodule

`default_nettype wire

/* rtl/exception_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exception_unit (
    input  mips_pkg::status_t  status,
    input  mips_pkg::cause_t   cause,
    input  logic [5:0]         ext_int,
    input  mips_pkg::word_t    pc,
    input  logic               fetch_adel,
    input  logic               inst_ri,
    input  logic               inst_syscall,
    input  logic               inst_break,
    input  logic               overflow,
    input  logic               mem_adel,
    input  logic               mem_ades,
    input  mips_pkg::word_t    mem_addr,
    output logic               exc_valid,
    output mips_pkg::exccode_t exc_code,
    output mips_pkg::word_t    exc_badvaddr
);
    import mips_pkg::*;

    logic [7:0] pending;
    logic [7:0] masked;
    logic       int_req;

    // ----------------------------------------
    // interrupt qualification
    // ----------------------------------------
    assign pending = {ext_int, 2'b00} | cause.ip;   // live lines plus stored bits
    assign masked  = pending & status.im;
    assign int_req = status.ie & ~status.exl & (|masked);

    // ----------------------------------------
    // fixed priority pick
    // ----------------------------------------
    always_comb begin
        exc_valid    = 1'b1;
        exc_code     = CODE_INT;
        exc_badvaddr = '0;

        if (int_req) begin
            exc_code = CODE_INT;
        end else if (fetch_adel) begin
            exc_code     = CODE_ADEL;
            exc_badvaddr = pc;       // fetch address was bad
        end else if (inst_ri) begin
            exc_code = CODE_RI;
        end else if (inst_syscall) begin
            exc_code = CODE_SYS;
        end else if (inst_break) begin
            exc_code = CODE_BP;
        end else if (overflow) begin
            exc_code = CODE_OV;
        end else if (mem_adel) begin
            exc_code     = CODE_ADEL;
            exc_badvaddr = mem_addr;
        end else if (mem_ades) begin
            exc_code     = CODE_ADES;
            exc_badvaddr = mem_addr;
        end else begin
            exc_valid = 1'b0;        // nothing pending
        end
    end

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [4:0]  exccode_t;

    // ----------------------------------------
    // exception codes
    // ----------------------------------------
    localparam exccode_t CODE_INT  = 5'd0;
    localparam exccode_t CODE_ADEL = 5'd4;
    localparam exccode_t CODE_ADES = 5'd5;
    localparam exccode_t CODE_SYS  = 5'd8;
    localparam exccode_t CODE_BP   = 5'd9;
    localparam exccode_t CODE_RI   = 5'd10;
    localparam exccode_t CODE_OV   = 5'd12;

    // ----------------------------------------
    // register layouts
    // ----------------------------------------
    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;          // bit 22, tied high
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [4:0] zero_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [13:0] zero_29_16;
        logic [7:0]  ip;          // 7..2 hardware, 1..0 software
        logic        zero_7;
        exccode_t    exccode;
        logic [1:0]  zero_1_0;
    } cause_t;

    typedef struct packed {
        word_t   badvaddr;
        word_t   count;
        word_t   compare;
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   config_;
    } cp0_regs_t;

    // ----------------------------------------
    // reset values and addresses
    // ----------------------------------------
    localparam status_t STATUS_RESET = '{bev: 1'b1, erl: 1'b1, default: '0};
    localparam word_t   CONFIG_VALUE = 32'h8000_0000;

    localparam cp0_regs_t CP0_RESET = '{
        status:  STATUS_RESET,
        config_: CONFIG_VALUE,
        default: '0
    };

    localparam word_t EXC_VECTOR = 32'hBFC0_0380;

    localparam creg_addr_t REG_BADVADDR = 5'd8;
    localparam creg_addr_t REG_COUNT    = 5'd9;
    localparam creg_addr_t REG_COMPARE  = 5'd11;
    localparam creg_addr_t REG_STATUS   = 5'd12;
    localparam creg_addr_t REG_CAUSE    = 5'd13;
    localparam creg_addr_t REG_EPC      = 5'd14;
    localparam creg_addr_t REG_CONFIG   = 5'd16;

endpackage

`default_nettype wire

/* rtl/pc_select.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_select (
    input  mips_pkg::word_t pc,
    input  logic            exc_valid,
    input  logic            is_eret,
    input  mips_pkg::word_t epc,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t next_pc,
    output logic            flush
);
    import mips_pkg::*;

    word_t seq_pc;

    assign seq_pc = pc + 32'd4;

    // ----------------------------------------
    // next fetch address
    // ----------------------------------------
    always_comb begin
        if (exc_valid) begin
            next_pc = EXC_VECTOR;
        end else if (is_eret) begin
            next_pc = epc;           // return from handler
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    // redirect through cp0 kills younger stages
    assign flush = exc_valid | is_eret;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f --top-module cp0_tb -Mdir obj_dir

./obj_dir/Vcp0_tb | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* tests/cp0_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_asserts (
    input logic              clk,
    input logic              reset,
    input logic              exc_valid,
    input logic              is_eret,
    input logic              flush,
    input mips_pkg::word_t   next_pc,
    input mips_pkg::word_t   epc,
    input mips_pkg::status_t status
);
    import mips_pkg::*;

    // redirect goes to the handler or back to EPC
    flush_target: assert property (@(posedge clk) disable iff (reset)
        flush |-> (next_pc == EXC_VECTOR || next_pc == epc))
        else $error("flush with next_pc %h, epc %h", next_pc, epc);

    no_exc_in_reset: assert property (@(posedge clk) reset |-> !exc_valid)
        else $error("exception request while reset is high");

    // same-cycle eret may clear EXL again
    exl_after_exc: assert property (@(posedge clk) disable iff (reset)
        (exc_valid && !is_eret) |=> status.exl)
        else $error("EXL not set after exception entry");

endmodule

bind cp0_top cp0_asserts u_cp0_asserts (
    .clk       (clk),
    .reset     (reset),
    .exc_valid (exc_valid),
    .is_eret   (is_eret),
    .flush     (flush),
    .next_pc   (next_pc),
    .epc       (epc),
    .status    (status)
);

`default_nettype wire

/* tests/cp0_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cp0_tb;
    import mips_pkg::*;

    localparam int TIMER_DIV   = 2;
    localparam int RAND_CYCLES = 600;
    localparam int MAX_CYCLES  = RAND_CYCLES + 400;   // directed part is about 120

    // exc_flags bit 6 is fetch_adel, then ri, syscall, break, ov, mem_adel, mem_ades
    localparam exccode_t FLAG_CODE [7] = '{CODE_ADES, CODE_ADEL, CODE_OV, CODE_BP,
                                           CODE_SYS, CODE_RI, CODE_ADEL};
    localparam creg_addr_t RAND_ADDR [8] = '{REG_BADVADDR, REG_COUNT, REG_COMPARE,
                                             REG_STATUS, REG_CAUSE, REG_EPC,
                                             REG_CONFIG, 5'd0};

    typedef struct packed {
        logic     exc;
        exccode_t code;
        word_t    bad;
        word_t    next_pc;
        logic     flush;
    } sel_t;

    logic       clk;
    logic       reset;
    logic       cwrite_en;
    creg_addr_t cwrite_addr;
    word_t      cwrite_data;
    creg_addr_t read_addr;
    logic       is_eret;
    word_t      pc;
    logic       in_delay_slot;
    logic [6:0] exc_flags;
    word_t      mem_addr;
    logic [5:0] ext_int;
    logic       branch_taken;
    word_t      branch_target;
    word_t      read_data;
    word_t      next_pc;
    logic       flush;

    cp0_regs_t  model;
    int         model_div;
    sel_t       step_sel;
    sel_t       check_sel;
    int         cycles = 0;
    integer     seed = 9118;
    word_t      r;
    word_t      q;

    cp0_top #(
        .TIMER_DIV (TIMER_DIV)
    ) u_dut (
        .*,
        .fetch_adel   (exc_flags[6]),
        .inst_ri      (exc_flags[5]),
        .inst_syscall (exc_flags[4]),
        .inst_break   (exc_flags[3]),
        .overflow     (exc_flags[2]),
        .mem_adel     (exc_flags[1]),
        .mem_ades     (exc_flags[0])
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic sel_t ref_select(cp0_regs_t s);
        sel_t       o;
        logic [7:0] pend;
        pend = ({ext_int, 2'b00} | s.cause.ip) & s.status.im;
        o    = '0;
        o.exc = 1'b1;
        if (s.status.ie && !s.status.exl && pend != 8'd0) begin
            o.code = CODE_INT;
        end else if (exc_flags != 7'd0) begin
            for (int i = 0; i < 7; i++) begin
                if (exc_flags[i]) begin   // highest set bit wins
                    o.code = FLAG_CODE[i];
                    o.bad  = (i == 6) ? pc : mem_addr;
                end
            end
        end else begin
            o.exc = 1'b0;
        end
        o.flush   = o.exc | is_eret;
        o.next_pc = o.exc ? EXC_VECTOR : is_eret ? s.epc :
                    branch_taken ? branch_target : pc + 4;
        return o;
    endfunction

    function automatic cp0_regs_t ref_step(cp0_regs_t s, int div, sel_t sel);
        cp0_regs_t n;
        logic      wr;
        n  = s;
        wr = cwrite_en && !sel.exc;
        if (wr && cwrite_addr == REG_COUNT) begin
            n.count = cwrite_data;
        end else if (div == TIMER_DIV - 1) begin
            n.count = s.count + 1;
        end
        if (wr && cwrite_addr == REG_COMPARE) begin
            n.compare  = cwrite_data;
            n.cause.ti = 1'b0;
        end else if (s.count == s.compare) begin
            n.cause.ti = 1'b1;
        end
        if (wr && cwrite_addr == REG_STATUS) begin
            n.status.im  = cwrite_data[15:8];
            n.status.exl = cwrite_data[1];
            n.status.ie  = cwrite_data[0];
        end
        if (wr && cwrite_addr == REG_CAUSE) begin
            n.cause.ip[1:0] = cwrite_data[9:8];
        end
        if (wr && cwrite_addr == REG_EPC) begin
            n.epc = cwrite_data;
        end
        n.cause.ip[7:2] = {ext_int[5] | n.cause.ti, ext_int[4:0]};
        if (sel.exc && !s.status.exl) begin
            n.epc      = in_delay_slot ? pc - 4 : pc;
            n.cause.bd = in_delay_slot;
        end
        if (sel.exc) begin
            n.cause.exccode = sel.code;
            n.status.exl    = 1'b1;
        end
        if (sel.exc && (sel.code == CODE_ADEL || sel.code == CODE_ADES)) begin
            n.badvaddr = sel.bad;
        end
        if (is_eret && s.status.erl) begin
            n.status.erl = 1'b0;
        end else if (is_eret) begin
            n.status.exl = 1'b0;
        end
        return n;
    endfunction

    function automatic word_t ref_read(cp0_regs_t s, creg_addr_t addr);
        case (addr)
            REG_BADVADDR: return s.badvaddr;
            REG_COUNT:    return s.count;
            REG_STATUS:   return s.status;
            REG_CAUSE:    return s.cause;
            REG_EPC:      return s.epc;
            REG_CONFIG:   return s.config_;
            default:      return '0;   // Compare and unmapped numbers
        endcase
    endfunction

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic fail_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t want);
        if (got !== want) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, want));
        end
    endtask

    task automatic check_flag(string name, logic got, logic want);
        if (got !== want) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b",
                               $time, name, got, want));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            model     <= CP0_RESET;
            model_div <= 0;
        end else begin
            step_sel = ref_select(model);
            model <= ref_step(model, model_div, step_sel);
            if ((cwrite_en && !step_sel.exc && cwrite_addr == REG_COUNT) ||
                model_div == TIMER_DIV - 1) begin
                model_div <= 0;
            end else begin
                model_div <= model_div + 1;
            end
        end
    end

    always @(negedge clk) begin
        #4;   // just before the rising edge
        if (!reset) begin
            check_sel = ref_select(model);
            check_word("read_data", read_data, ref_read(model, read_addr));
            check_word("next_pc", next_pc, check_sel.next_pc);
            check_flag("flush", flush, check_sel.flush);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, stimulus never finished", cycles));
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic next_cycle();
        @(negedge clk);
        cwrite_en     = 1'b0;
        is_eret       = 1'b0;
        in_delay_slot = 1'b0;
        exc_flags     = '0;
        branch_taken  = 1'b0;
    endtask

    task automatic mtc0(creg_addr_t addr, word_t data);
        next_cycle();
        cwrite_en   = 1'b1;
        cwrite_addr = addr;
        cwrite_data = data;
    endtask

    task automatic mfc0(creg_addr_t addr);
        next_cycle();
        read_addr = addr;
    endtask

    task automatic do_eret();
        next_cycle();
        is_eret = 1'b1;
    endtask

    task automatic raise(logic [6:0] flags, logic ds, word_t at);
        next_cycle();
        exc_flags     = flags;
        in_delay_slot = ds;
        pc            = at;
        mem_addr      = at ^ 32'h0000_0F03;   // misaligned data address
    endtask

    initial begin
        reset         = 1'b1;
        cwrite_en     = 1'b0;
        cwrite_addr   = '0;
        cwrite_data   = '0;
        read_addr     = '0;
        is_eret       = 1'b0;
        pc            = 32'h0040_0000;
        in_delay_slot = 1'b0;
        exc_flags     = '0;
        mem_addr      = '0;
        ext_int       = 6'h3F;   // all lines pending while reset masks them
        branch_taken  = 1'b0;
        branch_target = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        ext_int = '0;

        mfc0(REG_STATUS);
        #2;
        check_word("read_data", read_data, 32'h0040_0004);   // BEV and ERL
        mfc0(5'd3);
        mfc0(REG_COMPARE);
        mtc0(REG_STATUS, 32'hFFFF_FFFF);
        mfc0(REG_STATUS);
        #2;
        check_word("read_data", read_data, 32'h0040_FF07);
        mtc0(REG_CAUSE, 32'hFFFF_FFFF);
        mfc0(REG_CAUSE);
        mtc0(REG_EPC, 32'h1234_5678);
        mfc0(REG_EPC);
        mtc0(REG_STATUS, 32'h0);
        do_eret();                   // first eret drops ERL only
        mfc0(REG_STATUS);
        #2;
        check_word("read_data", read_data, 32'h0040_0000);

        // timer match and clear
        mtc0(REG_COMPARE, 32'd20);
        mtc0(REG_COUNT, 32'd10);
        mfc0(REG_COUNT);
        repeat (24) next_cycle();
        mfc0(REG_CAUSE);
        #2;
        check_flag("cause_ti", read_data[30], 1'b1);
        mtc0(REG_COMPARE, 32'd5000);
        mfc0(REG_CAUSE);
        #2;
        check_flag("cause_ti", read_data[30], 1'b0);

        for (int i = 0; i < 7; i++) begin
            for (int ds = 0; ds < 2; ds++) begin
                raise(7'(1 << i), ds[0], 32'h0040_0100 + 32'(16 * i));
                mfc0(REG_EPC);
                mfc0(REG_CAUSE);
                mfc0(REG_BADVADDR);
                do_eret();
            end
        end

        // nested exception keeps the first EPC
        raise(7'b0001000, 1'b0, 32'h0040_0200);
        raise(7'b0000100, 1'b0, 32'h0040_0300);
        mfc0(REG_EPC);
        #2;
        check_word("read_data", read_data, 32'h0040_0200);
        do_eret();

        raise(7'h7F, 1'b1, 32'h0040_0400);
        mfc0(REG_CAUSE);
        #2;
        check_word("exccode", 32'(read_data[6:2]), 32'(CODE_ADEL));
        do_eret();
        raise(7'b0011111, 1'b0, 32'h0040_0500);
        mfc0(REG_CAUSE);
        do_eret();

        // line 0 interrupt stays masked until IE and IM[2]
        ext_int = 6'b000001;
        next_cycle();
        mtc0(REG_STATUS, 32'h0000_0401);
        next_cycle();
        #2;
        check_flag("flush", flush, 1'b1);
        mfc0(REG_CAUSE);
        ext_int = '0;
        do_eret();
        mtc0(REG_STATUS, 32'h0);
        next_cycle();
        branch_taken  = 1'b1;
        branch_target = 32'h0040_1000;

        for (int n = 0; n < RAND_CYCLES; n++) begin
            next_cycle();
            r = $random(seed);
            q = $random(seed);
            cwrite_en     = (r[2:0] == 3'd0);
            cwrite_addr   = RAND_ADDR[r[5:3]];
            cwrite_data   = $random(seed);
            read_addr     = RAND_ADDR[r[8:6]];
            is_eret       = (r[12:9] == 4'd0);
            pc            = {q[31:2], 2'b00};
            in_delay_slot = r[13];
            exc_flags     = (r[17:14] == 4'd0) ? 7'(1 << r[20:18]) : 7'd0;
            mem_addr      = $random(seed);
            ext_int       = (r[23:21] == 3'd0) ? r[29:24] : 6'd0;
            branch_taken  = r[30];
            branch_target = {q[15:0], q[31:16]};
        end
        next_cycle();
        @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/mips_pkg.sv
rtl/exception_unit.sv
rtl/pc_select.sv
rtl/cp0_regs.sv
rtl/cp0_top.sv
tests/cp0_asserts.sv
tests/cp0_tb.sv
